/* design/fas_pkg.sv */
`default_nettype none

package fas_pkg;

  // Stream samples, Q8.8
  typedef logic signed [15:0] sample_t;

  typedef logic signed [19:0] coef_t;   // Q4.16
  typedef logic signed [35:0] acc_t;    // Q12.24
  typedef logic signed [19:0] fixed_t;  // Q4.16
  typedef logic signed [39:0] prod_t;   // Q8.32

  // Real Q8.8 over imaginary Q8.8
  typedef logic [31:0] bin_t;

  localparam int NUM_TAPS   = 32;
  localparam int FRAME_LEN  = 16;
  localparam int LOG2_FRAME = 4;

  // Taps 0 to 15 since tap 31-i equals tap i
  localparam coef_t fir_coefs [NUM_TAPS/2] = '{
    20'shFFF9E,
    20'shFFF86,
    20'shFFFA7,
    20'sh0003B,
    20'sh0014B,
    20'sh0024A,
    20'sh00222,
    20'shFFFE4,
    20'shFFBC5,
    20'shFF7CA,
    20'shFF74E,
    20'shFFD74,
    20'sh00B1A,
    20'sh01DAC,
    20'sh02F9E,
    20'sh03AA9
  };

  // cos(2*pi*k/16)
  localparam fixed_t tw_re [FRAME_LEN/2] = '{
    20'sd65536,
    20'sd60547,
    20'sd46341,
    20'sd25080,
    20'sd0,
    -20'sd25080,
    -20'sd46341,
    -20'sd60547
  };

  // -sin(2*pi*k/16)
  localparam fixed_t tw_im [FRAME_LEN/2] = '{
    20'sd0,
    -20'sd25080,
    -20'sd46341,
    -20'sd60547,
    -20'sd65536,
    -20'sd60547,
    -20'sd46341,
    -20'sd25080
  };

endpackage

`default_nettype wire

/* design/fir_filter.sv */
`timescale 1ns/1ns
`default_nettype none

module fir_filter (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire fas_pkg::sample_t data,
  output fas_pkg::sample_t      fir_d,
  output logic                  fir_valid
);

  localparam int TAPS  = fas_pkg::NUM_TAPS;
  localparam int HALF  = TAPS / 2;
  localparam int CNT_W = $clog2(TAPS);

  fas_pkg::sample_t   taps [TAPS];      // Newest sample at the top
  logic signed [16:0] pair_sum [HALF];
  fas_pkg::acc_t      acc;
  logic [CNT_W-1:0]   warm_cnt;
  logic               round_up;

  // Delay line shifts every clock
  always_ff @(posedge clk)
  begin
    taps[TAPS-1] <= data;
    for (int i = 0; i < TAPS-1; i++)
    begin
      taps[i] <= taps[i+1];
    end
  end

  // Symmetric taps share one coefficient
  always_comb
  begin
    for (int i = 0; i < HALF; i++)
    begin
      pair_sum[i] = taps[i] + taps[TAPS-1-i];
    end
  end

  always_comb
  begin
    acc = '0;
    for (int i = 0; i < HALF; i++)
    begin
      acc = acc + pair_sum[i] * fas_pkg::fir_coefs[i];  // Q8.8 x Q4.16
    end
  end

  // Round toward zero by moving negative sums with a nonzero remainder up one LSB
  assign round_up = acc[35] && (acc[15:0] != '0);
  assign fir_d    = acc[31:16] + {15'd0, round_up};

  // Warm-up until the delay line is full
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      warm_cnt  <= '0;
      fir_valid <= 1'b0;
    end
    else if (!fir_valid)
    begin
      warm_cnt <= warm_cnt + 1'b1;
      if (warm_cnt == CNT_W'(TAPS - 1))
      begin
        fir_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/frame_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_collector (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire fas_pkg::sample_t fir_d,
  input  wire logic             fir_valid,
  output fas_pkg::fixed_t       frame_re [fas_pkg::FRAME_LEN],
  output logic                  frame_valid
);

  localparam int N     = fas_pkg::FRAME_LEN;
  localparam int CNT_W = $clog2(N);

  fas_pkg::fixed_t  win      [N];   // Oldest at index 0
  fas_pkg::fixed_t  win_next [N];
  fas_pkg::fixed_t  sample_fx;
  logic [CNT_W-1:0] cnt;
  logic             frame_done;

  // Q8.8 into Q4.16 dropping the upper integer bits
  assign sample_fx  = {fir_d[11:0], 8'h00};
  assign frame_done = fir_valid && (cnt == CNT_W'(N - 1));

  always_comb
  begin
    for (int k = 0; k < N-1; k++)
    begin
      win_next[k] = win[k+1];
    end
    win_next[N-1] = sample_fx;
  end

  always_ff @(posedge clk)
  begin
    if (fir_valid)
    begin
      win <= win_next;
    end
    if (frame_done)
    begin
      frame_re <= win_next;  // Held while the frame is in the pipeline
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cnt         <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= frame_done;
      if (fir_valid)
      begin
        cnt <= cnt + 1'b1;  // Wraps every frame
      end
    end
  end

endmodule

`default_nettype wire

/* design/fft_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fft_stage #(
  parameter int STAGE = 0
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire fas_pkg::fixed_t in_re [fas_pkg::FRAME_LEN],
  input  wire fas_pkg::fixed_t in_im [fas_pkg::FRAME_LEN],
  input  wire logic            in_valid,
  output fas_pkg::fixed_t      out_re [fas_pkg::FRAME_LEN],
  output fas_pkg::fixed_t      out_im [fas_pkg::FRAME_LEN],
  output logic                 out_valid
);

  localparam int N    = fas_pkg::FRAME_LEN;
  localparam int SPAN = N >> (STAGE + 1);  // 8, 4, 2, 1

  fas_pkg::fixed_t nxt_re [N];
  fas_pkg::fixed_t nxt_im [N];

  always_comb
  begin
    int              lo;
    int              hi;
    int              tw;
    fas_pkg::fixed_t dif_re;
    fas_pkg::fixed_t dif_im;
    fas_pkg::prod_t  prod_re;
    fas_pkg::prod_t  prod_im;
    for (int b = 0; b < N/2; b++)
    begin
      lo = (b / SPAN) * 2 * SPAN + (b % SPAN);
      hi = lo + SPAN;
      tw = (b % SPAN) << STAGE;

      nxt_re[lo] = in_re[lo] + in_re[hi];
      nxt_im[lo] = in_im[lo] + in_im[hi];

      dif_re = in_re[lo] - in_re[hi];
      dif_im = in_im[lo] - in_im[hi];

      // Complex multiply by the twiddle into Q8.32
      prod_re = dif_re * fas_pkg::tw_re[tw] - dif_im * fas_pkg::tw_im[tw];
      prod_im = dif_re * fas_pkg::tw_im[tw] + dif_im * fas_pkg::tw_re[tw];

      nxt_re[hi] = prod_re[35:16];  // Back to Q4.16
      nxt_im[hi] = prod_im[35:16];
    end
  end

  // Runs every cycle so frames can overlap in the pipe
  always_ff @(posedge clk)
  begin
    out_re <= nxt_re;
    out_im <= nxt_im;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= in_valid;
    end
  end

endmodule

`default_nettype wire

/* design/spectrum_register.sv */
`timescale 1ns/1ns
`default_nettype none

module spectrum_register (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire fas_pkg::fixed_t in_re [fas_pkg::FRAME_LEN],
  input  wire fas_pkg::fixed_t in_im [fas_pkg::FRAME_LEN],
  input  wire logic            in_valid,
  output fas_pkg::bin_t        fft_d [fas_pkg::FRAME_LEN],
  output logic                 fft_valid
);

  localparam int N = fas_pkg::FRAME_LEN;

  function automatic int bit_rev(input int p);
    int r;
    r = 0;
    for (int i = 0; i < fas_pkg::LOG2_FRAME; i++)
    begin
      r = (r << 1) | ((p >> i) & 1);
    end
    return r;
  endfunction

  // Sign-extended integer part and top fraction byte
  function automatic logic [15:0] to_q88(input fas_pkg::fixed_t v);
    return {{4{v[19]}}, v[19:8]};
  endfunction

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      fft_valid <= 1'b0;
      for (int p = 0; p < N; p++)
      begin
        fft_d[p] <= '0;
      end
    end
    else
    begin
      fft_valid <= in_valid;
      if (in_valid)
      begin
        for (int p = 0; p < N; p++)
        begin
          fft_d[bit_rev(p)] <= {to_q88(in_re[p]), to_q88(in_im[p])};
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/fas_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fas_top (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire fas_pkg::sample_t data,
  output fas_pkg::sample_t      fir_d,
  output logic                  fir_valid,
  output fas_pkg::bin_t         fft_d [fas_pkg::FRAME_LEN],
  output logic                  fft_valid
);

  localparam int N      = fas_pkg::FRAME_LEN;
  localparam int STAGES = fas_pkg::LOG2_FRAME;

  // Entry s feeds stage s and the last entry feeds the output register
  fas_pkg::fixed_t st_re [STAGES+1][N];
  fas_pkg::fixed_t st_im [STAGES+1][N];
  logic [STAGES:0] st_valid;
  logic            frame_valid;

  fir_filter i_fir (
    .clk       (clk),
    .rst       (rst),
    .data      (data),
    .fir_d     (fir_d),
    .fir_valid (fir_valid)
  );

  frame_collector i_collect (
    .clk         (clk),
    .rst         (rst),
    .fir_d       (fir_d),
    .fir_valid   (fir_valid),
    .frame_re    (st_re[0]),
    .frame_valid (frame_valid)
  );

  assign st_valid[0] = frame_valid;

  // Real input frame
  for (genvar k = 0; k < N; k++)
  begin : g_zero_im
    assign st_im[0][k] = '0;
  end

  for (genvar s = 0; s < STAGES; s++)
  begin : g_stage
    fft_stage #(
      .STAGE (s)
    ) i_stage (
      .clk       (clk),
      .rst       (rst),
      .in_re     (st_re[s]),
      .in_im     (st_im[s]),
      .in_valid  (st_valid[s]),
      .out_re    (st_re[s+1]),
      .out_im    (st_im[s+1]),
      .out_valid (st_valid[s+1])
    );
  end

  spectrum_register i_spectrum (
    .clk       (clk),
    .rst       (rst),
    .in_re     (st_re[STAGES]),
    .in_im     (st_im[STAGES]),
    .in_valid  (st_valid[STAGES]),
    .fft_d     (fft_d),
    .fft_valid (fft_valid)
  );

endmodule

`default_nettype wire

/* testbench/fas_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module fas_properties (
  input wire logic clk,
  input wire logic rst,
  input wire logic fir_valid,
  input wire logic frame_valid,
  input wire logic fft_valid
);

  int fail_count = 0;

  // Output strobe is a single cycle
  a_fft_pulse: assert property (
    @(posedge clk) disable iff (rst) fft_valid |=> !fft_valid
  ) else
  begin
    fail_count++;
    $error("fft_valid high on two cycles in a row");
  end

  // Four stages plus the output register
  a_fft_latency: assert property (
    @(posedge clk) disable iff (rst) fft_valid == $past(frame_valid, 5)
  ) else
  begin
    fail_count++;
    $error("fft_valid not 5 cycles after frame_valid");
  end

  a_fir_valid_sticky: assert property (
    @(posedge clk) disable iff (rst) fir_valid |=> fir_valid
  ) else
  begin
    fail_count++;
    $error("fir_valid fell after rising");
  end

endmodule

bind fas_top fas_properties i_props (
  .clk         (clk),
  .rst         (rst),
  .fir_valid   (fir_valid),
  .frame_valid (frame_valid),
  .fft_valid   (fft_valid)
);

`default_nettype wire

/* testbench/fas_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fas_tb;

  localparam int  N              = fas_pkg::FRAME_LEN;
  localparam int  TAPS           = fas_pkg::NUM_TAPS;
  localparam int  RST_CYCLES     = 2;
  localparam int  NUM_FRAMES     = 20;
  localparam int  PIPE_DELAY     = 6;  // 16th valid fir_d to fft_valid
  localparam int  RUN_CYCLES     = RST_CYCLES + TAPS + NUM_FRAMES * N + PIPE_DELAY;
  localparam int  TIMEOUT_CYCLES = (RUN_CYCLES * 3 / 100) * 100;
  localparam real TOL            = 4.0;  // Q8.8 LSB
  localparam real PI             = 3.14159265358979;

  localparam int T_RESET   = 0;
  localparam int T_WARM    = 1;
  localparam int T_FILT    = 2;
  localparam int T_RATE    = 3;
  localparam int T_SPEC    = 4;
  localparam int T_HOLD    = 5;
  localparam int NUM_TESTS = 6;

  logic             clk;
  logic             rst;
  fas_pkg::sample_t data;
  fas_pkg::sample_t fir_d;
  logic             fir_valid;
  fas_pkg::bin_t    fft_d [N];
  logic             fft_valid;

  int               cyc;
  int               post_rst;       // Samples entered since reset release
  int               pulses;
  int               checks [NUM_TESTS];
  int               errs   [NUM_TESTS];
  fas_pkg::sample_t hist [$];       // Oldest first as in the delay line
  int               frame_acc [$];
  int               frame_q [$];    // N values per completed frame
  int               due_q [$];      // Expected fft_valid cycle per frame
  int               cur_frame [N];
  fas_pkg::bin_t    held [N];

  fas_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .data      (data),
    .fir_d     (fir_d),
    .fir_valid (fir_valid),
    .fft_d     (fft_d),
    .fft_valid (fft_valid)
  );

  always #20 clk = ~clk;

  function automatic string test_name(input int t);
    case (t)
      T_RESET: return "reset";
      T_WARM:  return "warm-up";
      T_FILT:  return "filter";
      T_RATE:  return "frame rate";
      T_SPEC:  return "spectrum";
      default: return "hold";
    endcase
  endfunction

  task automatic report_test(input int t);
    $display("Test %s: %0d checks, %0d errors", test_name(t), checks[t], errs[t]);
  endtask

  // Full-precision dot product and a division that truncates toward zero
  function automatic int fir_model();
    longint sum;
    int     c;
    sum = 0;
    for (int i = 0; i < TAPS; i++)
    begin
      c   = (i < TAPS/2) ? fas_pkg::fir_coefs[i] : fas_pkg::fir_coefs[TAPS-1-i];
      sum = sum + longint'(hist[i]) * longint'(c);
    end
    return int'(sum / 65536);
  endfunction

  // Direct DFT of cur_frame in Q8.8 LSB units
  task automatic check_spectrum(input int frame_no);
    real ang;
    real exp_re;
    real exp_im;
    int  act_re;
    int  act_im;
    for (int k = 0; k < N; k++)
    begin
      exp_re = 0.0;
      exp_im = 0.0;
      for (int n = 0; n < N; n++)
      begin
        ang    = 2.0 * PI * real'(k * n) / real'(N);
        exp_re = exp_re + real'(cur_frame[n]) * $cos(ang);
        exp_im = exp_im - real'(cur_frame[n]) * $sin(ang);
      end
      act_re = $signed(fft_d[k][31:16]);
      act_im = $signed(fft_d[k][15:0]);
      checks[T_SPEC] += 2;
      if (real'(act_re) - exp_re > TOL || exp_re - real'(act_re) > TOL)
      begin
        errs[T_SPEC]++;
        $display("Fail spectrum: frame %0d bin %0d real expected %0.2f actual %0d",
                 frame_no, k, exp_re, act_re);
      end
      if (real'(act_im) - exp_im > TOL || exp_im - real'(act_im) > TOL)
      begin
        errs[T_SPEC]++;
        $display("Fail spectrum: frame %0d bin %0d imag expected %0.2f actual %0d",
                 frame_no, k, exp_im, act_im);
      end
    end
  endtask

  // Stimulus and delay line model
  always @(posedge clk)
  begin
    cyc++;
    hist.push_back(data);
    if (hist.size() > TAPS)
    begin
      void'(hist.pop_front());
    end
    if (!rst)
    begin
      post_rst++;
      data <= fas_pkg::sample_t'(int'($urandom_range(128, 0)) - 64);  // Within +-0.25
    end
  end

  // Checks mid-cycle
  always @(negedge clk)
  begin
    int   exp_d;
    logic exp_pulse;
    if (!rst)
    begin
      exp_pulse = (due_q.size() > 0) && (due_q[0] == cyc);
      checks[T_RATE]++;
      if (fft_valid !== exp_pulse)
      begin
        errs[T_RATE]++;
        if (exp_pulse)
        begin
          $display("Missing fft_valid pulse at cycle %0d", cyc);
        end
        else
        begin
          $display("Unexpected fft_valid pulse at cycle %0d", cyc);
        end
      end
      if (exp_pulse)
      begin
        void'(due_q.pop_front());
        for (int n = 0; n < N; n++)
        begin
          cur_frame[n] = frame_q.pop_front();
        end
        pulses++;
        if (fft_valid)
        begin
          check_spectrum(pulses);
        end
      end

      if (fft_valid)
      begin
        for (int k = 0; k < N; k++)
        begin
          held[k] = fft_d[k];
        end
      end
      else
      begin
        for (int k = 0; k < N; k++)
        begin
          checks[T_HOLD]++;
          if (fft_d[k] !== held[k])
          begin
            errs[T_HOLD]++;
            $display("Fail hold: cycle %0d bin %0d expected %h actual %h",
                     cyc, k, held[k], fft_d[k]);
          end
        end
      end

      if (post_rst <= TAPS)
      begin
        checks[T_WARM]++;
        if (fir_valid !== (post_rst == TAPS))
        begin
          errs[T_WARM]++;
          $display("Fail warm-up: after %0d samples expected fir_valid %0d actual %0d",
                   post_rst, post_rst == TAPS, fir_valid);
        end
        if (post_rst == TAPS)
        begin
          report_test(T_WARM);
        end
      end
      else if (fir_valid !== 1'b1)
      begin
        errs[T_FILT]++;
        $display("fir_valid dropped at cycle %0d", cyc);
      end

      if (post_rst >= TAPS)
      begin
        exp_d = fir_model();
        checks[T_FILT]++;
        if (fir_d !== fas_pkg::sample_t'(exp_d))
        begin
          errs[T_FILT]++;
          $display("Fail filter: cycle %0d expected %0d actual %0d", cyc, exp_d, fir_d);
        end
        frame_acc.push_back(exp_d);
        if (frame_acc.size() == N)
        begin
          for (int n = 0; n < N; n++)
          begin
            frame_q.push_back(frame_acc[n]);
          end
          frame_acc.delete();
          due_q.push_back(cyc + PIPE_DELAY);
        end
      end
    end
  end

  initial
  begin
    int total_checks;
    int total_errs;
    int assert_errs;
    clk      = 1'b0;
    rst      = 1'b1;
    data     = '0;
    cyc      = 0;
    post_rst = 0;
    pulses   = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      checks[t] = 0;
      errs[t]   = 0;
    end
    for (int k = 0; k < N; k++)
    begin
      held[k] = '0;
    end
    void'($urandom(32));

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checks[T_RESET] += 2;
    if (fir_valid !== 1'b0)
    begin
      errs[T_RESET]++;
      $display("Fail reset: fir_valid expected 0 actual %b", fir_valid);
    end
    if (fft_valid !== 1'b0)
    begin
      errs[T_RESET]++;
      $display("Fail reset: fft_valid expected 0 actual %b", fft_valid);
    end
    for (int k = 0; k < N; k++)
    begin
      checks[T_RESET]++;
      if (fft_d[k] !== '0)
      begin
        errs[T_RESET]++;
        $display("Fail reset: bin %0d expected 00000000 actual %h", k, fft_d[k]);
      end
    end
    report_test(T_RESET);

    while (pulses < NUM_FRAMES) @(posedge clk);
    repeat (4) @(posedge clk);  // A few more hold checks

    report_test(T_FILT);
    report_test(T_RATE);
    report_test(T_SPEC);
    report_test(T_HOLD);
    assert_errs = i_dut.i_props.fail_count;
    $display("Assertions: %0d failures", assert_errs);
    total_checks = 0;
    total_errs   = assert_errs;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      total_checks += checks[t];
      total_errs   += errs[t];
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks, total_errs);
    if (total_errs == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial
  begin
    while (cyc < TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* fas.f */
design/fas_pkg.sv
design/fir_filter.sv
design/frame_collector.sv
design/fft_stage.sv
design/spectrum_register.sv
design/fas_top.sv
testbench/fas_properties.sv
testbench/fas_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := fas_tb
FILELIST  := fas.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+100
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
